// File: dv/tb_csr_unit.sv
`timescale 1ns/1ps

module tb_csr_unit;
  import csr_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 3;
  localparam int N_RW         = 400;
  localparam int N_ILLEGAL    = 200;
  localparam int N_ECALL      = 150;
  localparam int N_MRET       = 150;
  localparam int N_CYCLES     = RESET_CYCLES + 8 + N_RW + N_ILLEGAL + N_ECALL + N_MRET + 1;

  logic        clk;
  logic        reset_x;
  csr_req_t    req;
  logic        ecall;
  logic        mret;
  logic [31:0] pc;
  logic [31:0] rd_data;
  logic        illegal;
  redirect_t   redirect;
  logic [31:0] mstatus;

  // model index order: mstatus mie mtvec mscratch mepc mcause mtval mip
  logic [31:0] model [0:7];
  logic [11:0] map_addr [0:7];
  logic [11:0] bad_addr [0:3];
  logic [31:0] rng_state;
  string       test_name;
  int          error_count;

  csr_unit i_csr_unit (
    .clk      (clk),
    .reset_x  (reset_x),
    .req      (req),
    .ecall    (ecall),
    .mret     (mret),
    .pc       (pc),
    .rd_data  (rd_data),
    .illegal  (illegal),
    .redirect (redirect),
    .mstatus  (mstatus)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // watchdog
  initial begin
    #((N_CYCLES + 20) * CLK_PERIOD);
    $display("watchdog expired before the test sequence finished");
    $display("FAIL: see errors above");
    $fatal(1);
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic draw(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  // -1 for an unmapped address
  function automatic int csr_index(input logic [11:0] a);
    int idx;
    idx = -1;
    for (int i = 0; i < 8; i++) begin
      if (map_addr[i] == a) begin
        idx = i;
      end
    end
    return idx;
  endfunction

  task automatic reset_model();
    for (int i = 0; i < 8; i++) begin
      model[i] = '0;
    end
    model[0] = 32'h0000_1888;
    model[3] = 32'h0802_0000;
  endtask

  // applies what the dut sees at this rising edge
  task automatic update_model();
    int idx;
    idx = csr_index(req.addr);
    if (!reset_x) begin
      reset_model();
    end else if (ecall) begin
      model[4] = pc;
      model[5] = 32'd11;
      model[0][7] = model[0][3];
      model[0][3] = 1'b0;
    end else if (mret) begin
      model[0][3] = model[0][7];
      model[0][7] = 1'b1;
    end else if (idx >= 0) begin
      if (req.op == CSR_RW) begin
        model[idx] = req.src;
      end else if (req.op == CSR_RS && req.src != '0) begin
        model[idx] = model[idx] | req.src;
      end else if (req.op == CSR_RC && req.src != '0) begin
        model[idx] = model[idx] & ~req.src;
      end
    end
  endtask

  task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      error_count++;
      $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  task automatic check_outputs();
    int          idx;
    logic [31:0] exp_rd;
    logic        exp_illegal;
    idx = csr_index(req.addr);
    exp_rd = '0;
    if (idx >= 0) begin
      exp_rd = model[idx];
    end
    exp_illegal = (req.op != CSR_NONE) && (idx < 0);
    compare("rd_data", exp_rd, rd_data);
    compare("illegal", {31'd0, exp_illegal}, {31'd0, illegal});
    compare("redirect.valid", {31'd0, ecall | mret}, {31'd0, redirect.valid});
    // target only matters while valid
    if (ecall) begin
      compare("redirect.target", {model[2][31:2], 2'b00}, redirect.target);
    end else if (mret) begin
      compare("redirect.target", model[4], redirect.target);
    end
    compare("mstatus", model[0], mstatus);
  endtask

  task automatic next_edge();
    @(posedge clk);
    update_model();
    #1;
  endtask

  task automatic drive_read(input logic [11:0] addr);
    req.op   = CSR_NONE;
    req.addr = addr;
    req.src  = '0;
    ecall    = 1'b0;
    mret     = 1'b0;
  endtask

  // rates are out of 256
  task automatic drive_random(input logic [7:0] bad_rate, input logic [7:0] ecall_rate,
                              input logic [7:0] mret_rate);
    logic [31:0] r;
    logic [31:0] s;
    logic [31:0] t;
    logic [31:0] u;
    draw(r);
    draw(s);
    draw(t);
    draw(u);
    req.op = csr_op_e'(r[1:0]);
    if (r[23:16] < bad_rate) begin
      req.addr = bad_addr[r[9:8]];
    end else begin
      req.addr = map_addr[r[12:10]];
    end
    // zero source about one time in eight
    req.src = (r[15:13] == 3'd0) ? '0 : s;
    ecall   = (t[7:0] < ecall_rate);
    mret    = (t[15:8] < mret_rate);
    pc      = {u[31:2], 2'b00};
  endtask

  task automatic run_phase(input string name, input int cycles, input logic [7:0] bad_rate,
                           input logic [7:0] ecall_rate, input logic [7:0] mret_rate);
    test_name = name;
    repeat (cycles) begin
      next_edge();
      drive_random(bad_rate, ecall_rate, mret_rate);
      #1;
      check_outputs();
    end
  endtask

  initial begin
    reset_x     = 1'b0;
    req         = '0;
    ecall       = 1'b0;
    mret        = 1'b0;
    pc          = '0;
    rng_state   = 32'd89432;
    error_count = 0;
    test_name   = "reset";
    map_addr[0] = 12'h300;
    map_addr[1] = 12'h304;
    map_addr[2] = 12'h305;
    map_addr[3] = 12'h340;
    map_addr[4] = 12'h341;
    map_addr[5] = 12'h342;
    map_addr[6] = 12'h343;
    map_addr[7] = 12'h344;
    bad_addr[0] = 12'h301;
    bad_addr[1] = 12'h345;
    bad_addr[2] = 12'h7c0;
    bad_addr[3] = 12'hf14;
    reset_model();

    repeat (RESET_CYCLES) next_edge();
    reset_x = 1'b1;

    test_name = "reset_values";
    for (int i = 0; i < 8; i++) begin
      next_edge();
      drive_read(map_addr[i]);
      #1;
      check_outputs();
    end

    run_phase("rw_rs_rc", N_RW, 8'd0, 8'd0, 8'd0);
    run_phase("illegal_addr", N_ILLEGAL, 8'd128, 8'd0, 8'd0);
    run_phase("ecall_entry", N_ECALL, 8'd16, 8'd64, 8'd16);
    run_phase("mret_return", N_MRET, 8'd16, 8'd16, 8'd64);

    @(posedge clk);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: hdl/csr_file.sv
`timescale 1ns/1ps

module csr_file (
  input  logic               clk,
  input  logic               reset_x,
  input  logic [11:0]        rd_addr,
  input  logic               wr_en,
  input  logic [31:0]        wr_data,
  input  csr_pkg::trap_evt_e trap_evt,
  input  logic [31:0]        pc,
  output logic [31:0]        rd_data,
  output logic               hit,
  output logic [31:0]        mtvec,
  output logic [31:0]        mepc,
  output logic [31:0]        mstatus
);
  import csr_pkg::*;

  logic [XLEN-1:0] mstatus_q;
  logic [XLEN-1:0] mie_q;
  logic [XLEN-1:0] mtvec_q;
  logic [XLEN-1:0] mscratch_q;
  logic [XLEN-1:0] mepc_q;
  logic [XLEN-1:0] mcause_q;
  logic [XLEN-1:0] mtval_q;
  logic [XLEN-1:0] mip_q;

  // trap side effects take precedence over the instruction write
  always_ff @(posedge clk) begin
    if (!reset_x) begin
      mstatus_q  <= RST_MSTATUS;
      mie_q      <= '0;
      mtvec_q    <= '0;
      mscratch_q <= RST_MSCRATCH;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mtval_q    <= '0;
      mip_q      <= '0;
    end else if (trap_evt == TRAP_ECALL) begin
      mepc_q                  <= pc;
      mcause_q                <= CAUSE_ECALL_M;
      // stack mie into mpie
      mstatus_q[MSTATUS_MIE]  <= 1'b0;
      mstatus_q[MSTATUS_MPIE] <= mstatus_q[MSTATUS_MIE];
    end else if (trap_evt == TRAP_MRET) begin
      // unstack, mpie goes back to one
      mstatus_q[MSTATUS_MIE]  <= mstatus_q[MSTATUS_MPIE];
      mstatus_q[MSTATUS_MPIE] <= 1'b1;
    end else if (wr_en) begin
      case (rd_addr)
        ADDR_MSTATUS:  mstatus_q  <= wr_data;
        ADDR_MIE:      mie_q      <= wr_data;
        ADDR_MTVEC:    mtvec_q    <= wr_data;
        ADDR_MSCRATCH: mscratch_q <= wr_data;
        ADDR_MEPC:     mepc_q     <= wr_data;
        ADDR_MCAUSE:   mcause_q   <= wr_data;
        ADDR_MTVAL:    mtval_q    <= wr_data;
        ADDR_MIP:      mip_q      <= wr_data;
        default: begin
        end
      endcase
    end
  end

  // read mux, unmapped reads return zero
  always_comb begin
    rd_data = '0;
    hit     = 1'b1;
    case (rd_addr)
      ADDR_MSTATUS:  rd_data = mstatus_q;
      ADDR_MIE:      rd_data = mie_q;
      ADDR_MTVEC:    rd_data = mtvec_q;
      ADDR_MSCRATCH: rd_data = mscratch_q;
      ADDR_MEPC:     rd_data = mepc_q;
      ADDR_MCAUSE:   rd_data = mcause_q;
      ADDR_MTVAL:    rd_data = mtval_q;
      ADDR_MIP:      rd_data = mip_q;
      default:       hit     = 1'b0;
    endcase
  end

  assign mtvec   = mtvec_q;
  assign mepc    = mepc_q;
  assign mstatus = mstatus_q;

  // write suppression is decided in trap_ctrl and csr_rmw
  a_no_wr_during_trap: assert property (
    @(posedge clk) disable iff (!reset_x)
    !(wr_en && (trap_evt != TRAP_NONE))
  ) else $error("csr write enabled during trap event");

endmodule

// File: hdl/csr_pkg.sv
package csr_pkg;

  localparam int XLEN = 32;

  // operation carried by a csr instruction
  typedef enum logic [1:0] {
    CSR_NONE,
    CSR_RW,
    CSR_RS,
    CSR_RC
  } csr_op_e;

  // trap event seen in the current cycle
  typedef enum logic [1:0] {
    TRAP_NONE,
    TRAP_ECALL,
    TRAP_MRET
  } trap_evt_e;

  // one csr instruction from the datapath
  typedef struct packed {
    csr_op_e         op;
    logic [11:0]     addr;
    logic [XLEN-1:0] src;
  } csr_req_t;

  // fetch redirect
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] target;
  } redirect_t;

  // machine csr addresses
  localparam logic [11:0] ADDR_MSTATUS  = 12'h300;
  localparam logic [11:0] ADDR_MIE      = 12'h304;
  localparam logic [11:0] ADDR_MTVEC    = 12'h305;
  localparam logic [11:0] ADDR_MSCRATCH = 12'h340;
  localparam logic [11:0] ADDR_MEPC     = 12'h341;
  localparam logic [11:0] ADDR_MCAUSE   = 12'h342;
  localparam logic [11:0] ADDR_MTVAL    = 12'h343;
  localparam logic [11:0] ADDR_MIP      = 12'h344;

  // reset values, all other csrs come up as zero
  localparam logic [XLEN-1:0] RST_MSTATUS  = 32'h0000_1888;
  localparam logic [XLEN-1:0] RST_MSCRATCH = 32'h0802_0000;

  // environment call from m-mode
  localparam logic [XLEN-1:0] CAUSE_ECALL_M = 32'd11;

  // mstatus bit positions
  localparam int MSTATUS_MIE  = 3;
  localparam int MSTATUS_MPIE = 7;

endpackage

// File: hdl/csr_rmw.sv
`timescale 1ns/1ps

module csr_rmw (
  input  csr_pkg::csr_op_e op,
  input  logic [31:0]      src,
  input  logic [31:0]      old,
  input  logic             hit,
  input  logic             wr_block,
  output logic             wr_en,
  output logic [31:0]      wr_data,
  output logic             illegal
);
  import csr_pkg::*;

  logic op_valid;
  logic src_nz;
  logic may_write;

  assign op_valid = (op != CSR_NONE);
  assign src_nz   = (src != '0);

  // read-modify-write data
  always_comb begin
    case (op)
      CSR_RW:  wr_data = src;
      CSR_RS:  wr_data = old | src;
      CSR_RC:  wr_data = old & ~src;
      default: wr_data = old;
    endcase
  end

  // set or clear with a zero mask is a pure read
  always_comb begin
    case (op)
      CSR_RW:  may_write = 1'b1;
      CSR_RS:  may_write = src_nz;
      CSR_RC:  may_write = src_nz;
      default: may_write = 1'b0;
    endcase
  end

  assign wr_en   = may_write && hit && !wr_block;
  assign illegal = op_valid && !hit;

endmodule

// File: hdl/csr_unit.sv
`timescale 1ns/1ps

module csr_unit (
  input  logic              clk,
  input  logic              reset_x,
  input  csr_pkg::csr_req_t req,
  input  logic              ecall,
  input  logic              mret,
  input  logic [31:0]       pc,
  output logic [31:0]       rd_data,
  output logic              illegal,
  output csr_pkg::redirect_t redirect,
  output logic [31:0]       mstatus
);
  import csr_pkg::*;

  trap_evt_e       trap_evt;
  logic            wr_block;
  logic            wr_en;
  logic            hit;
  logic [XLEN-1:0] wr_data;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;

  // priority and redirect
  trap_ctrl i_trap_ctrl (
    .ecall    (ecall),
    .mret     (mret),
    .mtvec    (mtvec),
    .mepc     (mepc),
    .trap_evt (trap_evt),
    .wr_block (wr_block),
    .redirect (redirect)
  );

  // old value comes straight from the read mux
  csr_rmw i_csr_rmw (
    .op       (req.op),
    .src      (req.src),
    .old      (rd_data),
    .hit      (hit),
    .wr_block (wr_block),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .illegal  (illegal)
  );

  csr_file i_csr_file (
    .clk      (clk),
    .reset_x  (reset_x),
    .rd_addr  (req.addr),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .trap_evt (trap_evt),
    .pc       (pc),
    .rd_data  (rd_data),
    .hit      (hit),
    .mtvec    (mtvec),
    .mepc     (mepc),
    .mstatus  (mstatus)
  );

endmodule

// File: hdl/trap_ctrl.sv
`timescale 1ns/1ps

module trap_ctrl (
  input  logic               ecall,
  input  logic               mret,
  input  logic [31:0]        mtvec,
  input  logic [31:0]        mepc,
  output csr_pkg::trap_evt_e trap_evt,
  output logic               wr_block,
  output csr_pkg::redirect_t redirect
);
  import csr_pkg::*;

  logic [XLEN-1:0] trap_base;

  // direct mode only, low bits of mtvec are the mode field
  assign trap_base = {mtvec[XLEN-1:2], 2'b00};

  // ecall beats mret, both beat a csr write
  always_comb begin
    trap_evt = TRAP_NONE;
    if (ecall) begin
      trap_evt = TRAP_ECALL;
    end else if (mret) begin
      trap_evt = TRAP_MRET;
    end
  end

  assign wr_block = (trap_evt != TRAP_NONE);

  always_comb begin
    redirect.valid  = 1'b0;
    redirect.target = '0;
    case (trap_evt)
      TRAP_ECALL: begin
        redirect.valid  = 1'b1;
        redirect.target = trap_base;
      end
      TRAP_MRET: begin
        redirect.valid  = 1'b1;
        redirect.target = mepc;
      end
      default: begin
      end
    endcase
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# build the csr unit testbench with verilator, run it, then scan the log
LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -j 0 --top-module tb_csr_unit -f tb.f \
  > build.log 2>&1 || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/Vtb_csr_unit > "$LOG" 2>&1 || echo "simulation exited with an error" >> "$LOG"
cat "$LOG"

[ -s "$LOG" ] || { echo "simulation log is empty"; exit 1; }
grep -q "FAIL: see errors above" "$LOG" && exit 1 || exit 0

// File: tb.f
hdl/csr_pkg.sv
hdl/csr_file.sv
hdl/csr_rmw.sv
hdl/trap_ctrl.sv
hdl/csr_unit.sv
dv/tb_csr_unit.sv
